// ==== lsu_consts.svh ====
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// data and address width, one word
`define LSU_XLEN 32

// clint timer registers, mtime low and high word
`define MTIME_ADDR_LOW     32'h0200_BFF8
`define MTIME_ADDR_HIGH    32'h0200_BFFC

// mtimecmp low and high word
`define MTIMECMP_ADDR_LOW  32'h0200_4000
`define MTIMECMP_ADDR_HIGH 32'h0200_4004

// memory opcode width
`define MEMOP_W 4

// amo operation width
`define AMOOP_W 4

`endif

// ==== lsu_pkg.sv ====
`include "lsu_consts.svh"

package lsu_pkg;

    // one machine word
    typedef logic [`LSU_XLEN-1:0] word_t;

    // memory opcode from the execute stage
    typedef enum logic [`MEMOP_W-1:0] {
        MEM_NONE,
        MEM_LB,
        MEM_LBU,
        MEM_LH,
        MEM_LHU,
        MEM_LW,
        MEM_SB,
        MEM_SH,
        MEM_SW,
        MEM_LR_W,
        MEM_SC_W,
        MEM_AMO
    } mem_op_e;

    // amo kind, only meaningful with MEM_AMO
    typedef enum logic [`AMOOP_W-1:0] {
        AMO_SWAP,
        AMO_ADD,
        AMO_XOR,
        AMO_AND,
        AMO_OR,
        AMO_MIN,
        AMO_MAX,
        AMO_MINU,
        AMO_MAXU
    } amo_op_e;

    // atomic sequencer states
    typedef enum logic [1:0] {
        AMO_IDLE,
        AMO_LOAD,
        AMO_CALC,
        AMO_STORE
    } amo_state_e;

endpackage

// ==== lsu_decode.sv ====
`timescale 1ns/1ps

module lsu_decode (
    input  lsu_pkg::mem_op_e mem_op_i,
    output logic             is_load_o,
    output logic             is_store_o,
    output logic             is_lr_o,
    output logic             is_sc_o,
    output logic             is_amo_o,
    output logic             ls_signed_o,
    // one-hot: bit 0 byte, bit 1 half, bit 2 word
    output logic [2:0]       size_o
);
    import lsu_pkg::*;

    always_comb begin
        is_load_o   = 1'b0;
        is_store_o  = 1'b0;
        is_lr_o     = 1'b0;
        is_sc_o     = 1'b0;
        is_amo_o    = 1'b0;
        ls_signed_o = 1'b0;
        size_o      = 3'b000;
        case (mem_op_i)
            MEM_NONE: ;
            // plain loads
            MEM_LB:  begin is_load_o = 1'b1; ls_signed_o = 1'b1; size_o = 3'b001; end
            MEM_LBU: begin is_load_o = 1'b1; size_o = 3'b001; end
            MEM_LH:  begin is_load_o = 1'b1; ls_signed_o = 1'b1; size_o = 3'b010; end
            MEM_LHU: begin is_load_o = 1'b1; size_o = 3'b010; end
            MEM_LW:  begin is_load_o = 1'b1; ls_signed_o = 1'b1; size_o = 3'b100; end
            // plain stores
            MEM_SB:  begin is_store_o = 1'b1; size_o = 3'b001; end
            MEM_SH:  begin is_store_o = 1'b1; size_o = 3'b010; end
            MEM_SW:  begin is_store_o = 1'b1; size_o = 3'b100; end
            // atomics are always a full word
            MEM_LR_W: begin
                is_lr_o = 1'b1;
                size_o  = 3'b100;
            end
            MEM_SC_W: begin
                is_sc_o = 1'b1;
                size_o  = 3'b100;
            end
            MEM_AMO: begin
                is_amo_o = 1'b1;
                size_o   = 3'b100;
            end
            default: ;
        endcase
    end

endmodule

// ==== lsu_load_ext.sv ====
`timescale 1ns/1ps

module lsu_load_ext (
    input  lsu_pkg::word_t rdata_i,
    input  logic [1:0]     offset_i,
    input  logic [2:0]     size_i,
    input  logic           signed_i,
    output lsu_pkg::word_t data_o
);
    import lsu_pkg::*;

    word_t shifted;
    logic  sign_b;
    logic  sign_h;

    // bring the addressed byte down to lane 0
    assign shifted = rdata_i >> {offset_i, 3'b000};

    // fill bit for byte and half loads
    assign sign_b = signed_i & shifted[7];
    assign sign_h = signed_i & shifted[15];

    always_comb begin
        if (size_i[0]) begin
            data_o = {{24{sign_b}}, shifted[7:0]};
        end else if (size_i[1]) begin
            data_o = {{16{sign_h}}, shifted[15:0]};
        end else begin
            // word or no access, pass the whole word
            data_o = shifted;
        end
    end

endmodule

// ==== lsu_amo_unit.sv ====
`timescale 1ns/1ps

module lsu_amo_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             amo_valid_i,
    input  logic             is_lr_i,
    input  logic             is_sc_i,
    input  logic             is_amo_i,
    input  logic             plain_store_i,
    input  lsu_pkg::amo_op_e amo_op_i,
    input  lsu_pkg::word_t   addr_i,
    input  lsu_pkg::word_t   rs2_data_i,
    input  logic             mem_data_ready_i,
    input  lsu_pkg::word_t   mem_rdata_i,
    output logic             amo_rd_req_o,
    output logic             amo_wr_req_o,
    output lsu_pkg::word_t   amo_wdata_o,
    output lsu_pkg::word_t   amo_result_o,
    output logic             amo_done_o,
    output logic             busy_o
);
    import lsu_pkg::*;

    amo_state_e state_q;
    logic       amo_valid_q;
    logic       start;
    logic       sc_match;
    logic       done_q;
    logic       resv_valid_q;
    word_t      resv_addr_q;
    word_t      loaded_q;
    word_t      calc_q;
    word_t      calc_d;
    word_t      result_q;

    // previous amo_valid for edge detection
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            amo_valid_q <= 1'b0;
        end else begin
            amo_valid_q <= amo_valid_i;
        end
    end

    // new atomic only on a rising edge while idle
    assign start = amo_valid_i & ~amo_valid_q & (is_lr_i | is_sc_i | is_amo_i)
                 & (state_q == AMO_IDLE);

    // sc succeeds only on the reserved word
    assign sc_match = resv_valid_q & (resv_addr_q == addr_i);

    // amo arithmetic on the old value and rs2
    always_comb begin
        case (amo_op_i)
            AMO_SWAP: calc_d = rs2_data_i;
            AMO_ADD:  calc_d = loaded_q + rs2_data_i;
            AMO_XOR:  calc_d = loaded_q ^ rs2_data_i;
            AMO_AND:  calc_d = loaded_q & rs2_data_i;
            AMO_OR:   calc_d = loaded_q | rs2_data_i;
            AMO_MIN:  calc_d = ($signed(loaded_q) < $signed(rs2_data_i)) ? loaded_q : rs2_data_i;
            AMO_MAX:  calc_d = ($signed(loaded_q) > $signed(rs2_data_i)) ? loaded_q : rs2_data_i;
            AMO_MINU: calc_d = (loaded_q < rs2_data_i) ? loaded_q : rs2_data_i;
            AMO_MAXU: calc_d = (loaded_q > rs2_data_i) ? loaded_q : rs2_data_i;
            default:  calc_d = rs2_data_i;
        endcase
    end

    // sequencer, done pulse and reservation flag
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q      <= AMO_IDLE;
            done_q       <= 1'b0;
            resv_valid_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                AMO_IDLE: begin
                    if (start) begin
                        if (is_lr_i) begin
                            state_q      <= AMO_LOAD;
                            resv_valid_q <= 1'b1;
                        end else if (is_amo_i) begin
                            state_q      <= AMO_LOAD;
                            resv_valid_q <= 1'b0;
                        end else if (sc_match) begin
                            state_q <= AMO_STORE;
                        end else begin
                            // failed sc finishes at once, no memory access
                            done_q       <= 1'b1;
                            resv_valid_q <= 1'b0;
                        end
                    end
                end
                AMO_LOAD: begin
                    // wait for the read word, lr ends here
                    if (mem_data_ready_i) begin
                        if (is_lr_i) begin
                            done_q  <= 1'b1;
                            state_q <= AMO_IDLE;
                        end else begin
                            state_q <= AMO_CALC;
                        end
                    end
                end
                AMO_CALC: begin
                    state_q <= AMO_STORE;
                end
                AMO_STORE: begin
                    if (mem_data_ready_i) begin
                        done_q       <= 1'b1;
                        resv_valid_q <= 1'b0;
                        state_q      <= AMO_IDLE;
                    end
                end
                default: begin
                    state_q <= AMO_IDLE;
                end
            endcase
            // any plain store drops the reservation
            if (plain_store_i) begin
                resv_valid_q <= 1'b0;
            end
        end
    end

    // data path registers, held while the cache stalls
    always_ff @(posedge clk) begin
        if (start && is_lr_i) begin
            resv_addr_q <= addr_i;
        end
        if (state_q == AMO_LOAD && mem_data_ready_i) begin
            loaded_q <= mem_rdata_i;
        end
        if (state_q == AMO_CALC) begin
            calc_q <= calc_d;
        end
        // lr returns the loaded word, amo the old word, sc 0 or 1
        if (start && is_sc_i && !sc_match) begin
            result_q <= word_t'(1);
        end else if (state_q == AMO_LOAD && mem_data_ready_i && is_lr_i) begin
            result_q <= mem_rdata_i;
        end else if (state_q == AMO_STORE && mem_data_ready_i) begin
            result_q <= is_sc_i ? word_t'(0) : loaded_q;
        end
    end

    assign amo_rd_req_o = (state_q == AMO_LOAD);
    assign amo_wr_req_o = (state_q == AMO_STORE);
    // sc stores rs2, amo stores the computed word
    assign amo_wdata_o  = is_sc_i ? rs2_data_i : calc_q;
    assign amo_result_o = result_q;
    assign amo_done_o   = done_q;
    // busy already in the start cycle so the stage holds
    assign busy_o       = start | (state_q != AMO_IDLE);

endmodule

// ==== lsu_top.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_top (
    input  logic             clk,
    input  logic             rst,
    input  lsu_pkg::mem_op_e mem_op_i,
    input  lsu_pkg::amo_op_e amo_op_i,
    input  lsu_pkg::word_t   addr_i,
    input  lsu_pkg::word_t   rs2_data_i,
    input  logic             amo_valid_i,
    input  logic             mem_data_ready_i,
    input  lsu_pkg::word_t   mem_rdata_i,
    input  lsu_pkg::word_t   clint_rdata_i,
    output lsu_pkg::word_t   mem_addr_o,
    output logic             mem_addr_valid_o,
    output logic             mem_write_valid_o,
    output logic [3:0]       mem_mask_o,
    output logic [3:0]       mem_size_o,
    output lsu_pkg::word_t   mem_wdata_o,
    output lsu_pkg::word_t   clint_addr_o,
    output logic             clint_valid_o,
    output logic             clint_write_valid_o,
    output lsu_pkg::word_t   clint_wdata_o,
    output lsu_pkg::word_t   mem_data_o,
    output lsu_pkg::word_t   amo_result_o,
    output logic             amo_done_o,
    output logic             ls_valid_o,
    output logic             stall_o
);
    import lsu_pkg::*;

    logic       is_load, is_store, is_lr, is_sc, is_amo, ls_signed;
    logic [2:0] ls_size;
    logic       is_atomic;
    logic [1:0] offset;
    logic [3:0] size_mask;
    logic       clint_hit;
    logic       plain_req;
    logic       amo_rd_req, amo_wr_req, amo_busy;
    word_t      amo_wdata;
    word_t      store_data;
    word_t      load_word;
    word_t      load_data;

    lsu_decode u_decode (
        .mem_op_i    (mem_op_i),
        .is_load_o   (is_load),
        .is_store_o  (is_store),
        .is_lr_o     (is_lr),
        .is_sc_o     (is_sc),
        .is_amo_o    (is_amo),
        .ls_signed_o (ls_signed),
        .size_o      (ls_size)
    );

    assign is_atomic = is_lr | is_sc | is_amo;
    assign offset    = addr_i[1:0];

    // byte lanes of the access before alignment
    assign size_mask = ls_size[2] ? 4'b1111 :
                       ls_size[1] ? 4'b0011 :
                       ls_size[0] ? 4'b0001 : 4'b0000;

    // store data moved to the addressed lanes
    assign store_data = rs2_data_i << {offset, 3'b000};

    // timer registers live in the clint, not the cache
    assign clint_hit = (addr_i == `MTIME_ADDR_LOW)    | (addr_i == `MTIME_ADDR_HIGH) |
                       (addr_i == `MTIMECMP_ADDR_LOW) | (addr_i == `MTIMECMP_ADDR_HIGH);

    assign clint_valid_o       = clint_hit & (is_load | is_store);
    assign clint_write_valid_o = clint_valid_o & is_store;
    assign clint_addr_o        = addr_i;
    assign clint_wdata_o       = store_data;

    lsu_amo_unit u_amo (
        .clk              (clk),
        .rst              (rst),
        .amo_valid_i      (amo_valid_i),
        .is_lr_i          (is_lr),
        .is_sc_i          (is_sc),
        .is_amo_i         (is_amo),
        .plain_store_i    (is_store),
        .amo_op_i         (amo_op_i),
        .addr_i           (addr_i),
        .rs2_data_i       (rs2_data_i),
        .mem_data_ready_i (mem_data_ready_i),
        .mem_rdata_i      (mem_rdata_i),
        .amo_rd_req_o     (amo_rd_req),
        .amo_wr_req_o     (amo_wr_req),
        .amo_wdata_o      (amo_wdata),
        .amo_result_o     (amo_result_o),
        .amo_done_o       (amo_done_o),
        .busy_o           (amo_busy)
    );

    // plain request drops in its ready cycle
    assign plain_req = (is_load | is_store) & ~clint_hit & ~mem_data_ready_i;

    // sequencer owns the port while it requests
    assign mem_addr_valid_o  = plain_req | amo_rd_req | amo_wr_req;
    assign mem_write_valid_o = (amo_rd_req | amo_wr_req) ? amo_wr_req : (plain_req & is_store);
    assign mem_addr_o        = addr_i;
    assign mem_mask_o        = mem_write_valid_o ? (size_mask << offset) : size_mask;
    assign mem_size_o        = {1'b0, ls_size};
    assign mem_wdata_o       = amo_wr_req ? amo_wdata : store_data;

    // clint answers in the same cycle
    assign load_word = clint_hit ? clint_rdata_i : mem_rdata_i;

    lsu_load_ext u_load_ext (
        .rdata_i  (load_word),
        .offset_i (offset),
        .size_i   (ls_size),
        .signed_i (ls_signed),
        .data_o   (load_data)
    );

    // stage result, alu value for non memory ops
    assign mem_data_o = is_atomic ? amo_result_o :
                        is_load   ? load_data    : addr_i;

    assign ls_valid_o = is_load | is_store | is_atomic;
    assign stall_o    = mem_addr_valid_o | (amo_busy & ~amo_done_o);

endmodule

// ==== lsu_asserts.sv ====
`timescale 1ns/1ps

module lsu_asserts (
    input logic clk,
    input logic rst,
    input logic mem_addr_valid_i,
    input logic mem_write_valid_i,
    input logic clint_valid_i,
    input logic amo_done_i
);

    // a write strobe only rides on a cache request
    write_needs_request: assert property (
        @(posedge clk) disable iff (rst)
        mem_write_valid_i |-> mem_addr_valid_i
    ) else $error("cache write strobe high without a cache request");

    // done is a single cycle pulse
    done_is_pulse: assert property (
        @(posedge clk) disable iff (rst)
        amo_done_i |=> !amo_done_i
    ) else $error("amo done held high for two cycles");

    // timer accesses never reach the cache
    clint_not_cache: assert property (
        @(posedge clk) disable iff (rst)
        clint_valid_i |-> !mem_addr_valid_i
    ) else $error("clint access also raised a cache request");

endmodule

bind lsu_top lsu_asserts u_asserts (
    .clk               (clk),
    .rst               (rst),
    .mem_addr_valid_i  (mem_addr_valid_o),
    .mem_write_valid_i (mem_write_valid_o),
    .clint_valid_i     (clint_valid_o),
    .amo_done_i        (amo_done_o)
);

// ==== tb_lsu.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module tb_lsu;
    import lsu_pkg::*;

    logic       clk = 1'b0;
    logic       rst;
    mem_op_e    mem_op_i;
    amo_op_e    amo_op_i;
    word_t      addr_i, rs2_data_i, mem_rdata_i, clint_rdata_i;
    logic       amo_valid_i, mem_data_ready_i;
    word_t      mem_addr_o, mem_wdata_o, clint_addr_o, clint_wdata_o;
    word_t      mem_data_o, amo_result_o;
    logic       mem_addr_valid_o, mem_write_valid_o, clint_valid_o, clint_write_valid_o;
    logic [3:0] mem_mask_o, mem_size_o;
    logic       amo_done_o, ls_valid_o, stall_o;
    integer     seed = 3077;
    // cache model state, 16 words
    word_t      cache_mem [0:15];
    word_t      req_addr, req_wdata;
    logic [3:0] req_mask;
    logic       req_write;
    int         latency;

    always #4 clk = ~clk;

    lsu_top u_lsu_top (.*);

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        assert (act === exp)
        else abort_run($sformatf("Error %s: expected %h, actual %h", name, exp, act));
    endtask

    // address, one-hot size and valid flag of a plain access
    task automatic check_access_info(input string name, input word_t addr, input int nbytes);
        check_word({name, " size"}, word_t'(nbytes), word_t'(mem_size_o));
        check_word({name, " address"}, addr, mem_addr_o);
        check_word({name, " valid"}, 32'd1, word_t'(ls_valid_o));
    endtask

    // word after writing nbytes of data at byte offset off
    function automatic word_t store_result(word_t old, word_t data, int off, int nbytes);
        word_t w;
        int    b;
        w = old;
        for (b = 0; b < nbytes; b++) begin
            w[8*(off+b) +: 8] = data[8*b +: 8];
        end
        return w;
    endfunction

    // bytes at off, then sign or zero fill above them
    function automatic word_t load_result(word_t w, int off, int nbytes, logic sgn);
        word_t v;
        int    b;
        v = '0;
        for (b = 0; b < nbytes; b++) begin
            v[8*b +: 8] = w[8*(off+b) +: 8];
        end
        for (b = 8 * nbytes; b < 32; b++) begin
            v[b] = sgn & w[8*(off+nbytes)-1];
        end
        return v;
    endfunction

    // new memory word of each A-extension operation
    function automatic word_t amo_model(amo_op_e op, word_t a, word_t b);
        word_t r;
        case (op)
            AMO_SWAP: r = b;
            AMO_ADD:  r = a + b;
            AMO_XOR:  r = a ^ b;
            AMO_AND:  r = a & b;
            AMO_OR:   r = a | b;
            AMO_MIN:  r = ($signed(a) <= $signed(b)) ? a : b;
            AMO_MAX:  r = ($signed(a) >= $signed(b)) ? a : b;
            AMO_MINU: r = (a <= b) ? a : b;
            default:  r = (a >= b) ? a : b;
        endcase
        return r;
    endfunction

    // data cache, latches a request and answers 1 to 3 cycles later
    initial begin
        int i;
        int b;
        mem_data_ready_i = 1'b0;
        mem_rdata_i      = '0;
        for (i = 0; i < 16; i++) begin
            for (b = 0; b < 4; b++) begin
                cache_mem[i][8*b +: 8] = 8'((4 * i + b) * 37 + 129);
            end
        end
        forever begin
            @(negedge clk);
            if (mem_addr_valid_o) begin
                req_addr  = mem_addr_o;
                req_wdata = mem_wdata_o;
                req_mask  = mem_mask_o;
                req_write = mem_write_valid_o;
                latency   = 1 + int'(($random(seed) & 32'h7FFF_FFFF) % 3);
                repeat (latency) @(posedge clk);
                #1;
                mem_rdata_i = cache_mem[req_addr[5:2]];
                if (req_write) begin
                    for (b = 0; b < 4; b++) begin
                        if (req_mask[b]) begin
                            cache_mem[req_addr[5:2]][8*b +: 8] = req_wdata[8*b +: 8];
                        end
                    end
                end
                mem_data_ready_i = 1'b1;
                @(posedge clk);
                #1;
                mem_data_ready_i = 1'b0;
            end
        end
    end

    task automatic await_ready(input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (!mem_data_ready_i) begin
            n = n + 1;
            if (n > 20) begin
                abort_run($sformatf("timeout waiting for cache ready in %s", name));
            end
            @(negedge clk);
        end
    endtask

    task automatic write_plain(input mem_op_e op, input word_t addr, input word_t data,
                               input int nbytes);
        string name;
        word_t exp;
        name = $sformatf("%s at %h", op.name(), addr);
        exp  = store_result(cache_mem[addr[5:2]], data, int'(addr[1:0]), nbytes);
        mem_op_i   = op;
        addr_i     = addr;
        rs2_data_i = data;
        await_ready(name);
        check_word(name, exp, cache_mem[addr[5:2]]);
        check_access_info(name, addr, nbytes);
        @(posedge clk);
        #1;
        mem_op_i = MEM_NONE;
    endtask

    task automatic read_plain(input mem_op_e op, input word_t addr, input int nbytes,
                              input logic sgn);
        string name;
        word_t exp;
        name = $sformatf("%s at %h", op.name(), addr);
        exp  = load_result(cache_mem[addr[5:2]], int'(addr[1:0]), nbytes, sgn);
        mem_op_i = op;
        addr_i   = addr;
        await_ready(name);
        check_word(name, exp, mem_data_o);
        check_access_info(name, addr, nbytes);
        @(posedge clk);
        #1;
        mem_op_i = MEM_NONE;
    endtask

    // timer register load then store, both answered in the request cycle
    task automatic clint_access(input word_t addr);
        word_t data;
        clint_rdata_i = $random(seed);
        mem_op_i      = MEM_LW;
        addr_i        = addr;
        @(negedge clk);
        check_word("clint load valid", 32'd1, word_t'(clint_valid_o));
        check_word("clint load no write", 32'd0, word_t'(clint_write_valid_o));
        check_word("clint load no cache", 32'd0, word_t'(mem_addr_valid_o));
        check_word("clint load address", addr, clint_addr_o);
        check_word("clint load data", clint_rdata_i, mem_data_o);
        @(posedge clk);
        #1;
        data       = $random(seed);
        mem_op_i   = MEM_SW;
        rs2_data_i = data;
        @(negedge clk);
        check_word("clint store write", 32'd1, word_t'(clint_write_valid_o));
        check_word("clint store no cache", 32'd0, word_t'(mem_addr_valid_o));
        check_word("clint store address", addr, clint_addr_o);
        check_word("clint store data", data, clint_wdata_o);
        @(posedge clk);
        #1;
        mem_op_i = MEM_NONE;
    endtask

    // one atomic from the amo_valid edge to the done pulse
    task automatic run_atomic(input string name, input mem_op_e op, input amo_op_e aop,
                              input word_t addr, input word_t rs2, input word_t exp);
        int n;
        n           = 0;
        mem_op_i    = op;
        amo_op_i    = aop;
        addr_i      = addr;
        rs2_data_i  = rs2;
        amo_valid_i = 1'b1;
        @(negedge clk);
        while (!amo_done_o) begin
            check_word({name, " stall"}, 32'd1, word_t'(stall_o));
            n = n + 1;
            if (n > 40) begin
                abort_run($sformatf("timeout waiting for amo done in %s", name));
            end
            @(negedge clk);
        end
        check_word(name, exp, amo_result_o);
        @(posedge clk);
        #1;
        amo_valid_i = 1'b0;
        mem_op_i    = MEM_NONE;
        // amo_valid low for one edge before the next start
        @(posedge clk);
        #1;
    endtask

    initial begin
        int      k;
        word_t   a;
        word_t   old;
        word_t   rs2;
        amo_op_e aop;
        rst           = 1'b1;
        mem_op_i      = MEM_NONE;
        amo_op_i      = AMO_SWAP;
        addr_i        = '0;
        rs2_data_i    = '0;
        amo_valid_i   = 1'b0;
        clint_rdata_i = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_word("reset done", 32'd0, word_t'(amo_done_o));
        check_word("reset stall", 32'd0, word_t'(stall_o));
        check_word("reset ls valid", 32'd0, word_t'(ls_valid_o));
        @(posedge clk);
        #1;
        // every size at every legal offset
        for (k = 0; k < 4; k++) begin
            write_plain(MEM_SB, 32'h10 + word_t'(k), $random(seed), 1);
        end
        write_plain(MEM_SH, 32'h10, $random(seed), 2);
        write_plain(MEM_SH, 32'h12, $random(seed), 2);
        write_plain(MEM_SW, 32'h14, $random(seed), 4);
        for (k = 0; k < 4; k++) begin
            read_plain(MEM_LB, 32'h18 + word_t'(k), 1, 1'b1);
            read_plain(MEM_LBU, 32'h18 + word_t'(k), 1, 1'b0);
        end
        for (k = 0; k < 4; k += 2) begin
            read_plain(MEM_LH, 32'h18 + word_t'(k), 2, 1'b1);
            read_plain(MEM_LHU, 32'h18 + word_t'(k), 2, 1'b0);
        end
        read_plain(MEM_LW, 32'h14, 4, 1'b1);
        clint_access(`MTIME_ADDR_LOW);
        clint_access(`MTIME_ADDR_HIGH);
        clint_access(`MTIMECMP_ADDR_LOW);
        clint_access(`MTIMECMP_ADDR_HIGH);
        // nine amo kinds on random old words, words 7 to 15
        aop = AMO_SWAP;
        for (k = 0; k < 9; k++) begin
            a = 32'h1C + 4 * word_t'(k);
            write_plain(MEM_SW, a, $random(seed), 4);
            old = cache_mem[a[5:2]];
            rs2 = $random(seed);
            run_atomic($sformatf("amo %s", aop.name()), MEM_AMO, aop, a, rs2, old);
            check_word($sformatf("amo %s memory", aop.name()), amo_model(aop, old, rs2),
                       cache_mem[a[5:2]]);
            aop = aop.next();
        end
        // lr then sc on the same word
        run_atomic("lr", MEM_LR_W, AMO_SWAP, 32'h08, '0, cache_mem[2]);
        rs2 = $random(seed);
        run_atomic("sc after lr", MEM_SC_W, AMO_SWAP, 32'h08, rs2, 32'd0);
        check_word("sc after lr memory", rs2, cache_mem[2]);
        // reservation used up by the sc
        old = cache_mem[2];
        run_atomic("sc without lr", MEM_SC_W, AMO_SWAP, 32'h08, $random(seed), 32'd1);
        check_word("sc without lr memory", old, cache_mem[2]);
        run_atomic("lr", MEM_LR_W, AMO_SWAP, 32'h08, '0, cache_mem[2]);
        old = cache_mem[3];
        run_atomic("sc other word", MEM_SC_W, AMO_SWAP, 32'h0C, $random(seed), 32'd1);
        check_word("sc other word memory", old, cache_mem[3]);
        // plain store in between drops the reservation
        run_atomic("lr", MEM_LR_W, AMO_SWAP, 32'h08, '0, cache_mem[2]);
        write_plain(MEM_SW, 32'h04, $random(seed), 4);
        old = cache_mem[2];
        run_atomic("sc after store", MEM_SC_W, AMO_SWAP, 32'h08, $random(seed), 32'd1);
        check_word("sc after store memory", old, cache_mem[2]);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+.
lsu_pkg.sv
lsu_decode.sv
lsu_load_ext.sv
lsu_amo_unit.sv
lsu_top.sv
lsu_asserts.sv
tb_lsu.sv

// ==== Makefile ====
# Verilator build and run of the load/store unit testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build tb_lsu with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --top-module tb_lsu -Mdir obj_dir -f flist.f
	./obj_dir/Vtb_lsu

clean:
	rm -rf obj_dir
